// File: bottomPkg.sv
package bottomPkg;

	// General purpose registers, in write/read select order
	typedef enum logic [2:0] {
		regA,
		regB,
		regC,
		regD,
		regE,
		regH,
		regL
	} regSelT;

	// Address unit operations
	typedef enum logic [1:0] {
		aopHold,
		aopLoad,
		aopInc,
		aopDec
	} addrOpT;

	typedef struct packed {
		addrOpT      op;
		logic [15:0] value;    // Used by aopLoad only
	} addrCmdT;

	typedef struct packed {
		logic   wr;            // Write strobe for wrSel
		regSelT wrSel;
		regSelT rdSel;
		logic   irLoad;        // Load IR from data bus
	} regCmdT;

	// Accumulator bit groups
	typedef struct packed {
		logic bq4;             // A[1] | A[2] | A[3]
		logic bq5;             // A[5] | A[6] | A[7]
		logic bq7;             // A[4] | A[7]
	} accFlagsT;

	// Flags held in the upper nibble of temp Z
	typedef struct packed {
		logic c;               // Z[4]
		logic h;               // Z[5]
		logic n;               // Z[6]
		logic z;               // Z[7]
	} zFlagsT;

	localparam logic [15:0] ieAddr        = 16'hFFFF;
	localparam logic [15:0] irqVectorBase = 16'h0040;
	localparam logic [7:0]  busIdle       = 8'hFF;    // Precharged bus value

endpackage

// File: busAccess.sv
`timescale 1ns/1ps

module busAccess #(
	parameter int numIrq = 8
) (
	input  logic              CLK,
	input  logic              rstN,
	input  logic [15:0]       addr,
	input  logic              rd,
	input  logic              wr,
	input  logic [7:0]        dataIn,
	output logic [numIrq-1:0] ie,
	output logic [7:0]        dataOut
);

	import bottomPkg::*;

	logic       ieHit;       // Address is the IE register
	logic [7:0] ieRead;      // IE as seen on the bus

	assign ieHit = (addr == ieAddr);

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ie <= '0;
		end else if (wr && ieHit) begin
			ie <= dataIn[numIrq-1:0];    // Upper bits are not stored
		end
	end

	// Missing IE bits float high like the rest of the bus
	always_comb begin
		ieRead             = busIdle;
		ieRead[numIrq-1:0] = ie;
	end

	assign dataOut = (rd && ieHit) ? ieRead : busIdle;

	// IE only moves through a decoded write or a reset
	ieWriteOnly: assert property (
		@(posedge CLK) disable iff (!rstN)
		!$stable(ie) |-> ($past(wr && ieHit) || !$past(rstN))
	) else $error("IE changed without a write to 0x%h", ieAddr);

endmodule

// File: irqLogic.sv
`timescale 1ns/1ps

module irqLogic #(
	parameter int numIrq = 8
) (
	input  logic              CLK,
	input  logic              rstN,
	input  logic [numIrq-1:0] ie,
	input  logic [numIrq-1:0] irqTrig,
	input  logic              ime,
	input  logic              irqEnable,
	output logic [7:0]        irqAck,
	output logic [15:0]       irqVector,
	output logic              irqPending,
	output logic              irqTaken
);

	import bottomPkg::*;

	logic [numIrq-1:0] ifReg;     // Interrupt flags
	logic [numIrq-1:0] ifSet;
	logic [numIrq-1:0] ifClr;
	logic [numIrq-1:0] ackSel;    // Lowest pending flag, one-hot
	logic [2:0]        ackIdx;
	logic              ackFire;

	// Requests only latch where IE allows them
	assign ifSet = irqTrig & ie;

	// Isolate lowest set bit
	assign ackSel = ifReg & (-ifReg);

	// Index of the lowest set flag
	always_comb begin
		ackIdx = '0;
		for (int i = numIrq - 1; i >= 0; i--) begin
			if (ifReg[i]) begin
				ackIdx = 3'(i);
			end
		end
	end

	assign irqPending = (|ifReg) && ime;
	assign ackFire    = irqPending && irqEnable;
	assign ifClr      = ackFire ? ackSel : '0;

	// A fresh request wins over the clear of the same bit
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ifReg <= '0;
		end else begin
			ifReg <= (ifReg & ~ifClr) | ifSet;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			irqAck    <= '0;
			irqTaken  <= 1'b0;
			irqVector <= '0;
		end else begin
			irqAck   <= '0;                  // One cycle pulse
			irqTaken <= ackFire;
			if (ackFire) begin
				irqAck[numIrq-1:0] <= ackSel;
				irqVector          <= irqVectorBase + (16'(ackIdx) << 3);
			end
		end
	end

	ackOneHot: assert property (
		@(posedge CLK) disable iff (!rstN)
		$onehot0(irqAck)
	) else $error("irqAck not one-hot: %b", irqAck);

	takenMatchesAck: assert property (
		@(posedge CLK) disable iff (!rstN)
		irqTaken == (|irqAck)
	) else $error("irqTaken %b disagrees with irqAck %b", irqTaken, irqAck);

endmodule

// File: regFile.sv
`timescale 1ns/1ps

module regFile (
	input  logic              CLK,
	input  logic              rstN,
	input  bottomPkg::regCmdT regCmd,
	input  logic [7:0]        wrData,
	input  logic [7:0]        dataIn,
	input  logic              tempLoad,
	input  logic [7:0]        aluRes,
	output logic [7:0]        ir,
	output logic [7:0]        regData,
	output bottomPkg::accFlagsT accFlags,
	output bottomPkg::zFlagsT   zFlags
);

	import bottomPkg::*;

	localparam int numRegs = 7;

	logic [7:0] gpr [numRegs];    // Indexed by regSelT
	logic [7:0] zReg;             // Temp Z, loaded from ALU result
	logic [7:0] accVal;

	// Single write port
	always_ff @(posedge CLK) begin
		if (!rstN) begin
			for (int i = 0; i < numRegs; i++) begin
				gpr[i] <= '0;
			end
		end else if (regCmd.wr) begin
			gpr[regCmd.wrSel] <= wrData;
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			ir <= '0;
		end else if (regCmd.irLoad) begin
			ir <= dataIn;                 // Opcode fetch
		end
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			zReg <= '0;
		end else if (tempLoad) begin
			zReg <= aluRes;
		end
	end

	// Unused select code reads the idle bus
	always_comb begin
		if (regCmd.rdSel inside {regA, regB, regC, regD, regE, regH, regL}) begin
			regData = gpr[regCmd.rdSel];
		end else begin
			regData = busIdle;
		end
	end

	assign accVal = gpr[regA];

	// Accumulator group decode for the ALU
	assign accFlags.bq4 = |accVal[3:1];
	assign accFlags.bq5 = |accVal[7:5];
	assign accFlags.bq7 = accVal[4] | accVal[7];

	assign zFlags.c = zReg[4];
	assign zFlags.h = zReg[5];
	assign zFlags.n = zReg[6];
	assign zFlags.z = zReg[7];

	legalWrSel: assert property (
		@(posedge CLK) disable iff (!rstN)
		regCmd.wr |-> regCmd.wrSel inside {regA, regB, regC, regD, regE, regH, regL}
	) else $error("Write to unknown register code %0d", regCmd.wrSel);

endmodule

// File: addrIncDec.sv
`timescale 1ns/1ps

module addrIncDec (
	input  logic               CLK,
	input  logic               rstN,
	input  bottomPkg::addrCmdT addrCmd,
	output logic [15:0]        addr
);

	import bottomPkg::*;

	logic [15:0] addrNext;

	// Plus and minus one wrap around the 64K space
	always_comb begin
		case (addrCmd.op)
			aopLoad: addrNext = addrCmd.value;
			aopInc:  addrNext = addr + 16'd1;
			aopDec:  addrNext = addr - 16'd1;
			default: addrNext = addr;       // aopHold
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!rstN) begin
			addr <= '0;
		end else begin
			addr <= addrNext;
		end
	end

endmodule

// File: cpuBottom.sv
`timescale 1ns/1ps

module cpuBottom #(
	parameter int numIrq = 8
) (
	input  logic                CLK,
	input  logic                rstN,
	input  bottomPkg::addrCmdT  addrCmd,
	input  bottomPkg::regCmdT   regCmd,
	input  logic [7:0]          wrData,
	input  logic [7:0]          dataIn,
	input  logic                tempLoad,
	input  logic [7:0]          aluRes,
	input  logic                rd,
	input  logic                wr,
	input  logic [numIrq-1:0]   irqTrig,
	input  logic                ime,
	input  logic                irqEnable,
	output logic [15:0]         addr,
	output logic [7:0]          dataOut,
	output logic [7:0]          irqAck,
	output logic [15:0]         irqVector,
	output logic                irqPending,
	output logic                irqTaken,
	output logic [7:0]          ir,
	output logic [7:0]          regData,
	output bottomPkg::accFlagsT accFlags,
	output bottomPkg::zFlagsT   zFlags
);

	logic [numIrq-1:0] ie;    // IE register to interrupt logic

	busAccess #(.numIrq(numIrq)) busAcc (
		.CLK(CLK),
		.rstN(rstN),
		.addr(addr),
		.rd(rd),
		.wr(wr),
		.dataIn(dataIn),
		.ie(ie),
		.dataOut(dataOut)
	);

	irqLogic #(.numIrq(numIrq)) irq (
		.CLK(CLK),
		.rstN(rstN),
		.ie(ie),
		.irqTrig(irqTrig),
		.ime(ime),
		.irqEnable(irqEnable),
		.irqAck(irqAck),
		.irqVector(irqVector),
		.irqPending(irqPending),
		.irqTaken(irqTaken)
	);

	regFile regs (
		.CLK(CLK),
		.rstN(rstN),
		.regCmd(regCmd),
		.wrData(wrData),
		.dataIn(dataIn),
		.tempLoad(tempLoad),
		.aluRes(aluRes),
		.ir(ir),
		.regData(regData),
		.accFlags(accFlags),
		.zFlags(zFlags)
	);

	addrIncDec incDec (
		.CLK(CLK),
		.rstN(rstN),
		.addrCmd(addrCmd),
		.addr(addr)
	);

endmodule

// File: tbClock.sv
`timescale 1ns/1ps

module tbClock #(
	parameter int halfPeriod  = 2,    // 4 ns clock
	parameter int resetCycles = 8
) (
	output logic CLK,
	output logic rstN
);

	initial begin
		CLK = 1'b0;
		forever #halfPeriod CLK = ~CLK;
	end

	// Release on a rising edge, like the rest of the stimulus
	initial begin
		rstN = 1'b0;
		repeat (resetCycles) @(posedge CLK);
		rstN <= 1'b1;
	end

endmodule

// File: tbCpuBottom.sv
`timescale 1ns/1ps

module tbCpuBottom;

	import bottomPkg::*;

	localparam int          numIrq     = 8;
	localparam logic [15:0] ieLocation = 16'hFFFF;
	localparam logic [15:0] vecBase    = 16'h0040;

	logic CLK;
	logic rstN;
	addrCmdT addrCmd;
	regCmdT regCmd;
	logic [7:0] wrData, dataIn, aluRes, dataOut, irqAck, ir, regData;
	logic tempLoad, rd, wr, ime, irqEnable, irqPending, irqTaken;
	logic [numIrq-1:0] irqTrig;
	logic [15:0] addr, irqVector;
	accFlagsT accFlags;
	zFlagsT zFlags;

	// Reference model state
	logic [7:0] expIe, expFlags, flagsNext, expAck, expIr, expZreg, expDataOut, expRegData;
	logic [7:0] expRegs [8];
	logic [15:0] expAddr, expVector;
	logic expTaken, expPending, lowFound;
	logic [2:0] expLow, expAcc;
	logic [3:0] expZ;

	int errCount = 0;
	int errAtStart = 0;
	int testsRun = 0;
	int testsFailed = 0;
	logic [7:0] randByte;

	tbClock clkGen (.CLK(CLK), .rstN(rstN));

	cpuBottom #(.numIrq(numIrq)) u_dut (.*);

	// First pending flag, scanning up from bit 0
	always_comb begin
		expLow = 3'd0;
		lowFound = 1'b0;
		for (int i = 0; i < numIrq; i++) begin
			if (expFlags[i] && !lowFound) begin
				expLow = 3'(i);
				lowFound = 1'b1;
			end
		end
	end

	always_comb begin
		expPending = (expFlags != 8'h00) && ime;
		flagsNext = expFlags;
		if (expPending && irqEnable) begin
			flagsNext[expLow] = 1'b0;
		end
		flagsNext = flagsNext | (irqTrig & expIe);    // New request beats the clear
	end

	assign expDataOut = (rd && expAddr == ieLocation) ? expIe : 8'hFF;
	assign expRegData = (regCmd.rdSel == 3'd7) ? 8'hFF : expRegs[regCmd.rdSel];
	assign expAcc = {|expRegs[0][3:1], |expRegs[0][7:5], expRegs[0][4] | expRegs[0][7]};
	assign expZ = {expZreg[4], expZreg[5], expZreg[6], expZreg[7]};

	always @(posedge CLK) begin
		if (!rstN) begin
			expIe <= '0;
			expFlags <= '0;
			expAck <= '0;
			expTaken <= 1'b0;
			expVector <= '0;
			expIr <= '0;
			expZreg <= '0;
			expAddr <= '0;
			for (int i = 0; i < 8; i++) begin
				expRegs[i] <= '0;
			end
		end else begin
			if (wr && expAddr == ieLocation) begin
				expIe <= dataIn;
			end
			expFlags <= flagsNext;
			expAck <= '0;
			expTaken <= 1'b0;
			if (expPending && irqEnable) begin
				expAck <= 8'h01 << expLow;
				expVector <= vecBase + 16'(expLow) * 16'd8;
				expTaken <= 1'b1;
			end
			if (regCmd.wr) begin
				expRegs[regCmd.wrSel] <= wrData;
			end
			if (regCmd.irLoad) begin
				expIr <= dataIn;
			end
			if (tempLoad) begin
				expZreg <= aluRes;
			end
			case (addrCmd.op)
				aopLoad: expAddr <= addrCmd.value;
				aopInc:  expAddr <= expAddr + 16'd1;
				aopDec:  expAddr <= expAddr - 16'd1;
				default: expAddr <= expAddr;
			endcase
		end
	end

	task automatic reportValue(input string sigName, input logic [15:0] expV,
			input logic [15:0] gotV);
		errCount++;
		$display("[FAIL] t=%0t %s expected 0x%h got 0x%h", $time, sigName, expV, gotV);
	endtask

	chkDataOut: assert property (@(posedge CLK) disable iff (!rstN) dataOut == expDataOut)
		else reportValue("dataOut", 16'($sampled(expDataOut)), 16'($sampled(dataOut)));
	chkPending: assert property (@(posedge CLK) disable iff (!rstN) irqPending == expPending)
		else reportValue("irqPending", 16'($sampled(expPending)), 16'($sampled(irqPending)));
	chkAck: assert property (@(posedge CLK) disable iff (!rstN) irqAck == expAck)
		else reportValue("irqAck", 16'($sampled(expAck)), 16'($sampled(irqAck)));
	chkVector: assert property (@(posedge CLK) disable iff (!rstN) irqVector == expVector)
		else reportValue("irqVector", $sampled(expVector), $sampled(irqVector));
	chkTaken: assert property (@(posedge CLK) disable iff (!rstN) irqTaken == expTaken)
		else reportValue("irqTaken", 16'($sampled(expTaken)), 16'($sampled(irqTaken)));
	chkRegData: assert property (@(posedge CLK) disable iff (!rstN) regData == expRegData)
		else reportValue("regData", 16'($sampled(expRegData)), 16'($sampled(regData)));
	chkIr: assert property (@(posedge CLK) disable iff (!rstN) ir == expIr)
		else reportValue("ir", 16'($sampled(expIr)), 16'($sampled(ir)));
	chkAcc: assert property (@(posedge CLK) disable iff (!rstN) accFlags == expAcc)
		else reportValue("accFlags", 16'($sampled(expAcc)), 16'($sampled(accFlags)));
	chkZ: assert property (@(posedge CLK) disable iff (!rstN) zFlags == expZ)
		else reportValue("zFlags", 16'($sampled(expZ)), 16'($sampled(zFlags)));
	chkAddr: assert property (@(posedge CLK) disable iff (!rstN) addr == expAddr)
		else reportValue("addr", $sampled(expAddr), $sampled(addr));

	task automatic cycles(input int n);
		repeat (n) @(posedge CLK);
	endtask

	// Every helper returns just after a rising edge
	task automatic loadAddr(input logic [15:0] value);
		addrCmd <= '{op: aopLoad, value: value};
		cycles(1);
		addrCmd <= '{op: aopHold, value: 16'h0000};
	endtask

	task automatic stepAddr(input addrOpT op, input int n);
		addrCmd <= '{op: op, value: 16'h0000};
		cycles(n);
		addrCmd <= '{op: aopHold, value: 16'h0000};
		cycles(1);
	endtask

	task automatic busWrite(input logic [15:0] where, input logic [7:0] value);
		loadAddr(where);
		wr <= 1'b1;
		dataIn <= value;
		cycles(1);
		wr <= 1'b0;
	endtask

	task automatic writeReg(input int r, input logic [7:0] value);
		regCmd.wr <= 1'b1;
		regCmd.wrSel <= regSelT'(r);
		regCmd.rdSel <= regSelT'(r);
		wrData <= value;
		cycles(1);
		regCmd.wr <= 1'b0;
		cycles(1);                 // Read back on regData
	endtask

	task automatic waitTaken(input int want, input int limit, input string what);
		int seen;
		int waited;
		seen = 0;
		waited = 0;
		while (seen < want && waited < limit) begin
			@(posedge CLK);
			waited++;
			if (irqTaken) begin
				seen++;
			end
		end
		if (seen < want) begin
			errCount++;
			$display("Timeout: %s got %0d of %0d acknowledges in %0d cycles", what, seen,
				want, waited);
		end
	endtask

	task automatic startTest();
		errAtStart = errCount;
	endtask

	task automatic endTest(input string name);
		testsRun++;
		if (errCount == errAtStart) begin
			$display("test %s: ok", name);
		end else begin
			testsFailed++;
			$display("test %s: %0d errors", name, errCount - errAtStart);
		end
	endtask

	initial begin
		int waited;
		waited = 0;
		void'($urandom(68));
		addrCmd = '{op: aopHold, value: 16'h0000};
		regCmd = '{wr: 1'b0, wrSel: regA, rdSel: regA, irLoad: 1'b0};
		wrData = '0;
		dataIn = '0;
		aluRes = '0;
		tempLoad = 1'b0;
		rd = 1'b0;
		wr = 1'b0;
		irqTrig = '0;
		ime = 1'b0;
		irqEnable = 1'b0;
		while (!rstN && waited < 40) begin
			@(posedge CLK);
			waited++;
		end
		if (!rstN) begin
			errCount++;
			$display("Timeout: reset was never released");
		end
		cycles(1);

		startTest();
		randByte = 8'($urandom);
		busWrite(ieLocation, randByte);
		rd <= 1'b1;
		cycles(2);
		rd <= 1'b0;                // IE address with rd low
		cycles(2);
		loadAddr(16'($urandom_range(0, 32'hFFFE)));
		rd <= 1'b1;
		cycles(2);
		rd <= 1'b0;
		endTest("IE access");

		startTest();
		busWrite(ieLocation, 8'hFF);
		ime <= 1'b1;
		irqEnable <= 1'b1;
		irqTrig <= 8'b1010_0110;
		cycles(1);
		irqTrig <= 8'h00;
		waitTaken(4, 30, "priority");
		cycles(3);
		endTest("priority and vectors");

		startTest();
		busWrite(ieLocation, 8'h0F);
		irqTrig <= 8'hF0;          // All masked by IE
		cycles(1);
		irqTrig <= 8'h00;
		cycles(4);
		ime <= 1'b0;
		irqTrig <= 8'h01;
		cycles(1);
		irqTrig <= 8'h00;
		cycles(5);
		ime <= 1'b1;
		irqEnable <= 1'b0;
		cycles(5);
		irqEnable <= 1'b1;
		waitTaken(1, 10, "gated request");
		ime <= 1'b0;
		irqEnable <= 1'b0;
		cycles(2);
		endTest("gating");

		startTest();
		for (int r = 0; r < 7; r++) begin
			writeReg(r, 8'($urandom));
		end
		repeat (4) begin
			writeReg(0, 8'($urandom));    // More accumulator patterns
		end
		dataIn <= 8'($urandom);
		regCmd.irLoad <= 1'b1;
		cycles(1);
		regCmd.irLoad <= 1'b0;
		cycles(1);
		endTest("register file");

		startTest();
		repeat (6) begin
			aluRes <= 8'($urandom);
			tempLoad <= 1'b1;
			cycles(1);
			tempLoad <= 1'b0;
			cycles(1);
		end
		endTest("temporary Z");

		startTest();
		loadAddr(16'($urandom));
		cycles(1);
		stepAddr(aopInc, 3);
		stepAddr(aopDec, 5);
		loadAddr(16'hFFFF);
		stepAddr(aopInc, 1);
		loadAddr(16'h0000);
		stepAddr(aopDec, 1);
		stepAddr(aopHold, 3);
		endTest("address unit");

		$display("Tests: %0d run, %0d failed, %0d errors", testsRun, testsFailed, errCount);
		if (errCount == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

// File: list.f
bottomPkg.sv
busAccess.sv
irqLogic.sv
regFile.sv
addrIncDec.sv
cpuBottom.sv
tbClock.sv
tbCpuBottom.sv

// File: run.sh
#!/bin/sh
# Build and run the cpuBottom testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tbCpuBottom -f list.f -o simCpuBottom; then
	echo "Verilator build failed"
	exit 1
fi

if ! output=$(./obj_dir/simCpuBottom); then
	echo "$output"
	echo "Simulation exited with an error"
	exit 1
fi
echo "$output"

if echo "$output" | grep -qF '*** PASSED ***'; then
	exit 0
fi
exit 1
